//--- core.f
logic/core_pkg.sv
logic/fetch_if.sv
logic/mem_if.sv
logic/inst_fetch.sv
logic/exec_unit.sv
logic/mem_port.sv
logic/core.sv
tests/core_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := core_tb
FILELIST  := core.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/core_tb.sv
// testbench for the rv32i core
// icache and dcache models, directed tests, watchdog
`timescale 1ns/1ps

module core_tb;
  import core_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 5;
  localparam int MAX_INSTS  = 64;
  localparam int DMEM_WORDS = 128;
  localparam logic [31:0] SEED = 32'h065dec24;
  // addi x0, x0, 0
  localparam logic [31:0] NOP = 32'h0000_0013;
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  logic        clock;
  logic        reset;
  logic [31:0] icache2core_data;
  logic        icache2core_data_valid;
  logic [31:0] core2icache_addr;
  logic [31:0] dcache2core_data;
  logic        dcache2core_data_valid;
  logic        core2dcache_req;
  logic [31:0] core2dcache_addr;
  logic [31:0] core2dcache_data;
  logic        core2dcache_data_we;
  mem_size_t   core2dcache_data_size;

  logic [31:0] imem [MAX_INSTS];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] ref_mem [DMEM_WORDS];
  logic [31:0] rf [32];
  int          prog_len;
  logic        slow_dcache;
  logic [31:0] cur_mem_pc;

  // expected memory operations in program order
  logic [31:0] exp_pc [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_mask [$];
  logic        exp_we [$];
  mem_size_t   exp_size [$];

  core dut_i (.*);

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      fail_run();
    end
  endtask

  function automatic logic [31:0] imem_word(input logic [31:0] addr);
    if (addr < 32'(MAX_INSTS * 4)) begin
      return imem[addr[7:2]];
    end else begin
      return NOP;
    end
  endfunction

  // icache model with a new delay of 0 to 3 cycles per fetch address
  initial begin
    int          wait_cycles;
    logic [31:0] fetch_addr;
    wait_cycles = 0;
    fetch_addr = 32'hffff_ffff;
    icache2core_data_valid = 1'b0;
    icache2core_data = NOP;
    forever begin
      @(posedge clock);
      #1;
      if (core2icache_addr != fetch_addr) begin
        fetch_addr = core2icache_addr;
        wait_cycles = $urandom_range(3, 0);
      end else if (wait_cycles > 0) begin
        wait_cycles--;
      end
      icache2core_data = imem_word(core2icache_addr);
      icache2core_data_valid = (wait_cycles == 0);
    end
  end

  // dcache model answering 1 to 4 cycles after req and 8 more when slow
  initial begin
    int          wait_cycles;
    logic [6:0]  idx;
    logic [31:0] mask;
    dcache2core_data_valid = 1'b0;
    dcache2core_data = '0;
    forever begin
      @(posedge clock);
      #1;
      dcache2core_data_valid = 1'b0;
      if (core2dcache_req && !reset && exp_pc.size() == 0) begin
        $display("dcache request with no memory operation left in the program");
        fail_run();
      end else if (core2dcache_req && !reset) begin
        cur_mem_pc = exp_pc[0];
        wait_cycles = $urandom_range(4, 1) + (slow_dcache ? 8 : 0);
        repeat (wait_cycles - 1) begin
          @(posedge clock);
          #1;
        end
        mask = exp_mask.pop_front();
        idx = core2dcache_addr[8:2];
        compare("core2dcache_addr", core2dcache_addr, exp_addr.pop_front());
        compare("core2dcache_data_we", 32'(core2dcache_data_we), 32'(exp_we[0]));
        compare("core2dcache_data_size", 32'(core2dcache_data_size), 32'(exp_size.pop_front()));
        if (exp_we.pop_front()) begin
          compare("core2dcache_data", core2dcache_data & mask, exp_data[0] & mask);
          dmem[idx] = (dmem[idx] & ~mask) | (core2dcache_data & mask);
        end else begin
          dcache2core_data = dmem[idx];
        end
        void'(exp_data.pop_front());
        void'(exp_pc.pop_front());
        dcache2core_data_valid = 1'b1;
      end
    end
  end

  // buffer holds one word, so fetch stays within two words of execute
  always @(negedge clock) begin
    if (!reset && core2dcache_req && core2icache_addr > cur_mem_pc + 32'd8) begin
      $display("fetch address 0x%08h ran ahead of memory instruction at 0x%08h",
               core2icache_addr, cur_mem_pc);
      fail_run();
    end
  end

  initial begin
    #(NUM_TESTS * MAX_INSTS * 10 * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    fail_run();
  end

  task automatic emit(input logic [31:0] word);
    imem[6'(prog_len)] = word;
    prog_len++;
  endtask

  task automatic start_program();
    foreach (imem[i]) imem[i] = NOP;
    foreach (rf[i]) rf[i] = '0;
    prog_len = 0;
  endtask

  task automatic expect_mem(input logic we, input logic [1:0] f3, input logic [31:0] addr,
                            input logic [31:0] value);
    logic [31:0] mask;
    mem_size_t   size;
    case (f3)
      2'b00: begin
        mask = 32'h0000_00ff;
        size = MEM_BYTE;
      end
      2'b01: begin
        mask = 32'h0000_ffff;
        size = MEM_HALF;
      end
      default: begin
        mask = 32'hffff_ffff;
        size = MEM_WORD;
      end
    endcase
    exp_pc.push_back(32'(prog_len * 4));
    exp_addr.push_back(addr);
    exp_we.push_back(we);
    exp_size.push_back(size);
    exp_mask.push_back(mask << (8 * addr[1:0]));
    exp_data.push_back(value << (8 * addr[1:0]));
  endtask

  task automatic addi_insn(input int rd, input int rs1, input logic [11:0] imm);
    emit({imm, 5'(rs1), 3'b000, 5'(rd), OPCODE_OP_IMM});
    if (rd != 0) rf[5'(rd)] = rf[5'(rs1)] + {{20{imm[11]}}, imm};
  endtask

  // kind 0 add, 1 sub, 2 xor, 3 or, 4 and
  task automatic alu_insn(input int kind, input int rd, input int rs1, input int rs2);
    logic [31:0] a, b, r;
    logic [6:0]  f7;
    logic [2:0]  f3;
    a = rf[5'(rs1)];
    b = rf[5'(rs2)];
    f7 = 7'b0000000;
    case (kind)
      0: begin
        r = a + b;
        f3 = 3'b000;
      end
      1: begin
        r = a - b;
        f3 = 3'b000;
        f7 = 7'b0100000;
      end
      2: begin
        r = a ^ b;
        f3 = 3'b100;
      end
      3: begin
        r = a | b;
        f3 = 3'b110;
      end
      default: begin
        r = a & b;
        f3 = 3'b111;
      end
    endcase
    emit({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPCODE_OP});
    if (rd != 0) rf[5'(rd)] = r;
  endtask

  task automatic load_insn(input logic [2:0] f3, input int rd, input logic [11:0] addr);
    logic [31:0] word, lane, val;
    word = ref_mem[addr[8:2]];
    lane = word >> (8 * addr[1:0]);
    case (f3)
      F3_B:    val = {{24{lane[7]}}, lane[7:0]};
      F3_H:    val = {{16{lane[15]}}, lane[15:0]};
      F3_BU:   val = {24'b0, lane[7:0]};
      F3_HU:   val = {16'b0, lane[15:0]};
      default: val = word;
    endcase
    expect_mem(1'b0, f3[1:0], {20'b0, addr}, 32'b0);
    emit({addr, 5'd0, f3, 5'(rd), OPCODE_LOAD});
    if (rd != 0) rf[5'(rd)] = val;
  endtask

  task automatic store_insn(input logic [2:0] f3, input int rs2, input logic [11:0] addr);
    logic [31:0] mask;
    expect_mem(1'b1, f3[1:0], {20'b0, addr}, rf[5'(rs2)]);
    mask = exp_mask[$];
    ref_mem[addr[8:2]] = (ref_mem[addr[8:2]] & ~mask) |
                         ((rf[5'(rs2)] << (8 * addr[1:0])) & mask);
    emit({addr[11:5], 5'(rs2), 5'd0, f3, addr[4:0], OPCODE_STORE});
  endtask

  // reset, then run until every expected memory operation completed
  task automatic run_program();
    @(posedge clock);
    #1;
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    compare("core2icache_addr", core2icache_addr, 32'h0);
    compare("core2dcache_req", 32'(core2dcache_req), 32'h0);
    while (exp_pc.size() != 0) @(posedge clock);
    repeat (2) @(posedge clock);
  endtask

  task automatic alu_results();
    start_program();
    for (int r = 1; r <= 6; r++) addi_insn(r, 0, 12'($urandom));
    for (int k = 0; k < 10; k++) begin
      alu_insn(k % 5, 7 + k, 1 + $urandom_range(5, 0), 1 + $urandom_range(5, 0));
      store_insn(F3_W, 7 + k, 12'(12'h100 + 4 * k));
    end
    run_program();
  endtask

  task automatic zero_register();
    start_program();
    addi_insn(0, 0, 12'h5a5);
    store_insn(F3_W, 0, 12'h140);
    addi_insn(5, 0, 12'($urandom));
    alu_insn(0, 6, 0, 5);
    alu_insn(0, 7, 5, 0);
    store_insn(F3_W, 6, 12'h144);
    store_insn(F3_W, 7, 12'h148);
    run_program();
  endtask

  task automatic load_extension();
    logic [2:0] kinds [5];
    int         n;
    kinds = '{F3_B, F3_BU, F3_H, F3_HU, F3_W};
    n = 0;
    start_program();
    foreach (kinds[k]) begin
      for (int off = 0; off < 4; off += (1 << kinds[k][1:0])) begin
        load_insn(kinds[k], 1 + n % 8, 12'(4 * $urandom_range(63, 0) + off));
        store_insn(F3_W, 1 + n % 8, 12'(12'h180 + 4 * n));
        n++;
      end
    end
    run_program();
  endtask

  // one sub-word store per word, then read the merged word back
  task automatic store_merging();
    start_program();
    for (int b = 0; b < 4; b++) begin
      addi_insn(1, 0, 12'($urandom));
      store_insn(F3_B, 1, 12'(12'h1c0 + 4 * b + b));
      load_insn(F3_W, 3, 12'(12'h1c0 + 4 * b));
      store_insn(F3_W, 3, 12'(12'h1e0 + 4 * b));
    end
    for (int h = 0; h < 2; h++) begin
      addi_insn(2, 0, 12'($urandom));
      store_insn(F3_H, 2, 12'(12'h1d0 + 4 * h + 2 * h));
      load_insn(F3_W, 4, 12'(12'h1d0 + 4 * h));
      store_insn(F3_W, 4, 12'(12'h1f0 + 4 * h));
    end
    run_program();
  endtask

  task automatic fetch_backpressure();
    slow_dcache = 1'b1;
    start_program();
    for (int k = 0; k < 6; k++) begin
      addi_insn(k + 1, 0, 12'($urandom));
      store_insn(F3_W, k + 1, 12'(12'h160 + 4 * k));
    end
    run_program();
    slow_dcache = 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    reset = 1'b1;
    slow_dcache = 1'b0;
    cur_mem_pc = '0;
    prog_len = 0;
    foreach (imem[i]) imem[i] = NOP;
    // random data and its reference copy
    foreach (dmem[i]) begin
      dmem[i] = $urandom;
      ref_mem[i] = dmem[i];
    end
    alu_results();
    zero_register();
    load_extension();
    store_merging();
    fetch_backpressure();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- logic/core.sv
// in-order rv32i core top
// fetch, execute and data port blocks on the cache ports
`timescale 1ns/1ps

module core (
  input  logic                clock,
  input  logic                reset,

  // icache side
  input  logic [31:0]         icache2core_data,
  input  logic                icache2core_data_valid,
  output logic [31:0]         core2icache_addr,

  // dcache side
  input  logic [31:0]         dcache2core_data,
  input  logic                dcache2core_data_valid,
  output logic                core2dcache_req,
  output logic [31:0]         core2dcache_addr,
  output logic [31:0]         core2dcache_data,
  output logic                core2dcache_data_we,
  output core_pkg::mem_size_t core2dcache_data_size
);

  fetch_if fetch_bus ();
  mem_if   mem_bus ();

  inst_fetch if_i (
    .clock                  (clock),
    .reset                  (reset),
    .icache2core_data       (icache2core_data),
    .icache2core_data_valid (icache2core_data_valid),
    .core2icache_addr       (core2icache_addr),
    .fetch                  (fetch_bus.producer)
  );

  exec_unit ex_i (
    .clock (clock),
    .reset (reset),
    .fetch (fetch_bus.consumer),
    .mem   (mem_bus.requester)
  );

  mem_port mp_i (
    .clock                  (clock),
    .reset                  (reset),
    .mem                    (mem_bus.responder),
    .core2dcache_req        (core2dcache_req),
    .core2dcache_addr       (core2dcache_addr),
    .core2dcache_data       (core2dcache_data),
    .core2dcache_data_we    (core2dcache_data_we),
    .core2dcache_data_size  (core2dcache_data_size),
    .dcache2core_data       (dcache2core_data),
    .dcache2core_data_valid (dcache2core_data_valid)
  );

endmodule

//--- logic/mem_port.sv
// dcache request port
// store lane placement and load lane extract with extension
`timescale 1ns/1ps

module mem_port (
  input  logic               clock,
  input  logic               reset,
  mem_if.responder           mem,
  output logic               core2dcache_req,
  output logic [31:0]        core2dcache_addr,
  output logic [31:0]        core2dcache_data,
  output logic               core2dcache_data_we,
  output core_pkg::mem_size_t core2dcache_data_size,
  input  logic [31:0]        dcache2core_data,
  input  logic               dcache2core_data_valid
);
  import core_pkg::*;

  logic            unsigned_q;
  logic            finish;
  logic [XLEN-1:0] store_lanes;
  logic [XLEN-1:0] load_shifted;
  logic [XLEN-1:0] load_ext;

  assign finish = core2dcache_req && dcache2core_data_valid;

  // move the store data up to its byte offset
  always_comb begin
    case (mem.size)
      MEM_BYTE: store_lanes = {24'b0, mem.wdata[7:0]} << {mem.addr[1:0], 3'b000};
      MEM_HALF: store_lanes = {16'b0, mem.wdata[15:0]} << {mem.addr[1:0], 3'b000};
      default:  store_lanes = mem.wdata;
    endcase
  end

  assign load_shifted = dcache2core_data >> {core2dcache_addr[1:0], 3'b000};

  always_comb begin
    case (core2dcache_data_size)
      MEM_BYTE: load_ext = {{24{load_shifted[7] & ~unsigned_q}}, load_shifted[7:0]};
      MEM_HALF: load_ext = {{16{load_shifted[15] & ~unsigned_q}}, load_shifted[15:0]};
      default:  load_ext = dcache2core_data;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      core2dcache_req     <= 1'b0;
      core2dcache_data_we <= 1'b0;
      mem.done            <= 1'b0;
    end else begin
      mem.done <= finish;
      if (mem.start) begin
        core2dcache_req     <= 1'b1;
        core2dcache_data_we <= mem.we;
      end else if (finish) begin
        core2dcache_req <= 1'b0;
      end
    end
  end

  // request fields held stable while req is high
  always_ff @(posedge clock) begin
    if (mem.start) begin
      core2dcache_addr      <= mem.addr;
      core2dcache_data      <= store_lanes;
      core2dcache_data_size <= mem.size;
      unsigned_q            <= mem.unsigned_load;
    end
    if (finish) begin
      mem.rdata <= load_ext;
    end
  end

endmodule

//--- logic/exec_unit.sv
// single-issue execute stage
// decode, register file, alu, load/store start and load writeback
`timescale 1ns/1ps

module exec_unit (
  input  logic       clock,
  input  logic       reset,
  fetch_if.consumer  fetch,
  mem_if.requester   mem
);
  import core_pkg::*;

  logic [XLEN-1:0]           regs [NUM_REGS];

  logic [6:0]                opcode;
  logic [REG_INDEX_SIZE-1:0] rs1_idx;
  logic [REG_INDEX_SIZE-1:0] rs2_idx;
  logic [REG_INDEX_SIZE-1:0] rd_idx;
  logic [2:0]                funct3;
  logic [XLEN-1:0]           imm;
  logic                      sub_op;
  logic                      is_alu;
  logic                      is_load;
  logic                      is_store;

  logic [XLEN-1:0]           rs1_val;
  logic [XLEN-1:0]           rs2_val;
  logic [XLEN-1:0]           alu_b;
  logic [XLEN-1:0]           alu_out;

  logic                      busy;
  logic                      pending_load;
  logic [REG_INDEX_SIZE-1:0] load_rd;

  // view of the word picked by opcode
  always_comb begin
    opcode   = fetch.inst.r.opcode;
    rs1_idx  = '0;
    rs2_idx  = '0;
    rd_idx   = '0;
    funct3   = '0;
    imm      = '0;
    sub_op   = 1'b0;
    is_alu   = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        rs1_idx = fetch.inst.r.rs1;
        rs2_idx = fetch.inst.r.rs2;
        rd_idx  = fetch.inst.r.rd;
        funct3  = fetch.inst.r.funct3;
        sub_op  = fetch.inst.r.funct7[5];
        is_alu  = 1'b1;
      end
      OPCODE_OP_IMM, OPCODE_LOAD: begin
        rs1_idx = fetch.inst.i.rs1;
        rd_idx  = fetch.inst.i.rd;
        funct3  = fetch.inst.i.funct3;
        imm     = {{(XLEN-12){fetch.inst.i.imm[11]}}, fetch.inst.i.imm};
        is_alu  = (opcode == OPCODE_OP_IMM);
        is_load = (opcode == OPCODE_LOAD);
      end
      OPCODE_STORE: begin
        rs1_idx  = fetch.inst.s.rs1;
        rs2_idx  = fetch.inst.s.rs2;
        funct3   = fetch.inst.s.funct3;
        imm      = {{(XLEN-12){fetch.inst.s.imm_hi[6]}}, fetch.inst.s.imm_hi,
                    fetch.inst.s.imm_lo};
        is_store = 1'b1;
      end
      default: ;
    endcase
  end

  assign rs1_val = regs[rs1_idx];
  assign rs2_val = regs[rs2_idx];
  assign alu_b   = (opcode == OPCODE_OP) ? rs2_val : imm;

  always_comb begin
    case (funct3)
      3'b100:  alu_out = rs1_val ^ alu_b;
      3'b110:  alu_out = rs1_val | alu_b;
      3'b111:  alu_out = rs1_val & alu_b;
      default: alu_out = sub_op ? rs1_val - alu_b : rs1_val + alu_b;
    endcase
  end

  // one instruction in flight at a time
  assign fetch.take = fetch.valid && !busy;

  assign mem.start         = fetch.take && (is_load || is_store);
  assign mem.addr          = rs1_val + imm;
  assign mem.wdata         = rs2_val;
  assign mem.we            = is_store;
  assign mem.unsigned_load = funct3[2];

  always_comb begin
    case (funct3[1:0])
      2'b00:   mem.size = MEM_BYTE;
      2'b01:   mem.size = MEM_HALF;
      default: mem.size = MEM_WORD;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy         <= 1'b0;
      pending_load <= 1'b0;
      load_rd      <= '0;
    end else if (mem.start) begin
      busy         <= 1'b1;
      pending_load <= is_load;
      load_rd      <= rd_idx;
    end else if (mem.done) begin
      busy         <= 1'b0;
      pending_load <= 1'b0;
    end
  end

  // x0 is never written so it reads as zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (fetch.take && is_alu && rd_idx != '0) begin
      regs[rd_idx] <= alu_out;
    end else if (mem.done && pending_load && load_rd != '0) begin
      regs[load_rd] <= mem.rdata;
    end
  end

endmodule

//--- logic/inst_fetch.sv
// instruction fetch with program counter
// and a one-entry instruction buffer
`timescale 1ns/1ps

module inst_fetch (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] icache2core_data,
  input  logic        icache2core_data_valid,
  output logic [31:0] core2icache_addr,
  fetch_if.producer   fetch
);
  import core_pkg::*;

  logic [XLEN-1:0] pc;
  logic            capture;

  // room when empty or being drained this cycle
  assign capture = icache2core_data_valid && (!fetch.valid || fetch.take);

  assign core2icache_addr = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc          <= RESET_PC;
      fetch.valid <= 1'b0;
    end else begin
      if (capture) begin
        pc          <= pc + XLEN'(4);
        fetch.valid <= 1'b1;
      end else if (fetch.take) begin
        fetch.valid <= 1'b0;
      end
    end
  end

  // buffered word
  always_ff @(posedge clock) begin
    if (capture) begin
      fetch.inst <= inst_t'(icache2core_data);
    end
  end

endmodule

//--- logic/mem_if.sv
// load and store requests from execute to the data port
// start and done are single-cycle pulses
`timescale 1ns/1ps

interface mem_if;
  import core_pkg::*;

  logic            start;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] wdata;
  logic            we;
  mem_size_t       size;
  logic            unsigned_load;
  logic            done;
  // already extended to xlen
  logic [XLEN-1:0] rdata;

  modport requester (
    output start, addr, wdata, we, size, unsigned_load,
    input  done, rdata
  );

  modport responder (
    input  start, addr, wdata, we, size, unsigned_load,
    output done, rdata
  );

endinterface

//--- logic/fetch_if.sv
// fetch to execute instruction handoff
// valid is held until a cycle with take high
`timescale 1ns/1ps

interface fetch_if;
  import core_pkg::*;

  inst_t inst;
  logic  valid;
  logic  take;

  modport producer (
    output inst,
    output valid,
    input  take
  );

  modport consumer (
    input  inst,
    input  valid,
    output take
  );

endinterface

//--- logic/core_pkg.sv
// shared widths, reset pc and rv32i major opcodes
// memory access size enum
// instruction word union with r, i and s views
package core_pkg;

  localparam int XLEN           = 32;
  localparam int NUM_REGS       = 32;
  localparam int REG_INDEX_SIZE = 5;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_t;

  typedef union packed {
    struct packed {
      logic [6:0]                funct7;
      logic [REG_INDEX_SIZE-1:0] rs2;
      logic [REG_INDEX_SIZE-1:0] rs1;
      logic [2:0]                funct3;
      logic [REG_INDEX_SIZE-1:0] rd;
      logic [6:0]                opcode;
    } r;
    struct packed {
      logic [11:0]               imm;
      logic [REG_INDEX_SIZE-1:0] rs1;
      logic [2:0]                funct3;
      logic [REG_INDEX_SIZE-1:0] rd;
      logic [6:0]                opcode;
    } i;
    struct packed {
      logic [6:0]                imm_hi;
      logic [REG_INDEX_SIZE-1:0] rs2;
      logic [REG_INDEX_SIZE-1:0] rs1;
      logic [2:0]                funct3;
      logic [4:0]                imm_lo;
      logic [6:0]                opcode;
    } s;
  } inst_t;

endpackage
